// File: src/dcmi_pkg.sv
// dcmi capture shared widths, bus width codes and frame state encoding

package dcmi_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int DATA_W = 14;             // camera data bus, widest mode
    localparam int CNT_W  = 14;             // crop counters and crop registers
    localparam int WORD_W = 32;             // packed output word
    localparam int BYTE_W = 8;              // lane width for the 8-bit bus
    localparam int HALF_W = WORD_W / 2;     // lane width for 10/12/14-bit buses

    // --------------------
    // bus width codes
    // --------------------
    typedef enum logic [1:0] {
        W8  = 2'd0,
        W10 = 2'd1,
        W12 = 2'd2,
        W14 = 2'd3
    } bus_width_t;

    // --------------------
    // frame fsm states
    // --------------------
    typedef enum logic [2:0] {
        IDLE             = 3'd0,
        WAIT_FRAME_START = 3'd1,    // armed, waiting for vsync to open a frame
        WAIT_LINE_START  = 3'd2,    // inside a frame, between lines
        LINE_RECV        = 3'd3,    // taking pixels
        WAIT_LINE_END    = 3'd4,    // pixel crop reached, rest of line ignored
        WAIT_FRAME_END   = 3'd5,    // line crop reached, rest of frame ignored
        FRAME_END        = 3'd6     // single cycle, flush and irq
    } frame_state_t;

    // lanes per word minus one, used by the packer
    localparam logic [1:0] LANE_MAX_8B  = 2'd3;
    localparam logic [1:0] LANE_MAX_16B = 2'd1;

endpackage

// File: src/dcmi_sync_in.sv
// dcmi input stage: polarity correction, sync edge detect and masked data latch
`timescale 1ns/1ps

module dcmi_sync_in (
    input  logic                        pclk,
    input  logic                        rstn,
    input  logic                        block_en,
    input  logic                        hsync_polarity,
    input  logic                        vsync_polarity,
    input  dcmi_pkg::bus_width_t        data_bus_width,
    input  logic                        dcmi_vsync,
    input  logic                        dcmi_hsync,
    input  logic [dcmi_pkg::DATA_W-1:0] dcmi_data,
    output logic [dcmi_pkg::DATA_W-1:0] sample,
    output logic                        href,
    output logic                        frame_open,
    output logic                        frame_close,
    output logic                        line_open,
    output logic                        line_close
);

    logic                        vsync;
    logic                        hsync;
    logic                        vsync_d1;
    logic                        hsync_d1;
    logic [dcmi_pkg::DATA_W-1:0] data_mask;

    // corrected strobes are low while the frame or line is active
    assign vsync = dcmi_vsync ^ vsync_polarity;
    assign hsync = dcmi_hsync ^ hsync_polarity;

    // only the lanes of the configured width pass
    always_comb begin
        case (data_bus_width)
            dcmi_pkg::W8:  data_mask = {{(dcmi_pkg::DATA_W-8){1'b0}}, {8{1'b1}}};
            dcmi_pkg::W10: data_mask = {{(dcmi_pkg::DATA_W-10){1'b0}}, {10{1'b1}}};
            dcmi_pkg::W12: data_mask = {{(dcmi_pkg::DATA_W-12){1'b0}}, {12{1'b1}}};
            default:       data_mask = '1;  // full 14-bit bus
        endcase
    end

    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            vsync_d1 <= 1'b0;
            hsync_d1 <= 1'b0;
            sample   <= '0;
        end else if (!block_en) begin
            vsync_d1 <= 1'b0;
            hsync_d1 <= 1'b0;
            sample   <= '0;
        end else begin
            vsync_d1 <= vsync;
            hsync_d1 <= hsync;
            sample   <= dcmi_data & data_mask;
        end
    end

    // href lines up with the latched sample, not the pins
    assign href        = ~hsync_d1;
    assign frame_open  = vsync_d1 & ~vsync;     // falling edge
    assign frame_close = ~vsync_d1 & vsync;     // rising edge
    assign line_open   = hsync_d1 & ~hsync;
    assign line_close  = ~hsync_d1 & hsync;

endmodule

// File: src/dcmi_frame_fsm.sv
// dcmi frame and line state machine with line, frame start and frame end irq pulses
`timescale 1ns/1ps

module dcmi_frame_fsm (
    input  logic pclk,
    input  logic rstn,
    input  logic block_en,
    input  logic capture_en,
    input  logic snapshot_mode,
    input  logic frame_open,
    input  logic frame_close,
    input  logic line_open,
    input  logic line_close,
    input  logic pixel_crop_end,
    input  logic line_crop_end,
    output logic frame_begin,
    output logic line_begin,
    output logic line_done,
    output logic in_line,
    output logic frame_done,
    output logic line_irq_pulse,
    output logic frame_start_irq_pulse,
    output logic frame_end_irq_pulse
);

    dcmi_pkg::frame_state_t curr_st;
    dcmi_pkg::frame_state_t next_st;

    // --------------------
    // state register
    // --------------------
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn)
            curr_st <= dcmi_pkg::IDLE;
        else if (!block_en)
            curr_st <= dcmi_pkg::IDLE;
        else
            curr_st <= next_st;
    end

    always_comb begin
        next_st = curr_st;
        case (curr_st)
            dcmi_pkg::IDLE: begin
                if (capture_en)
                    next_st = dcmi_pkg::WAIT_FRAME_START;
            end
            dcmi_pkg::WAIT_FRAME_START: begin
                if (frame_open)
                    next_st = dcmi_pkg::WAIT_LINE_START;
            end
            dcmi_pkg::WAIT_LINE_START: begin
                if (frame_close)
                    next_st = dcmi_pkg::FRAME_END;
                else if (line_open)
                    next_st = dcmi_pkg::LINE_RECV;
            end
            dcmi_pkg::LINE_RECV: begin
                if (frame_close)            // frame cut short
                    next_st = dcmi_pkg::FRAME_END;
                else if (line_close)
                    next_st = line_crop_end ? dcmi_pkg::WAIT_FRAME_END
                                            : dcmi_pkg::WAIT_LINE_START;
                else if (pixel_crop_end)    // window width reached
                    next_st = dcmi_pkg::WAIT_LINE_END;
            end
            dcmi_pkg::WAIT_LINE_END: begin
                if (frame_close)
                    next_st = dcmi_pkg::FRAME_END;
                else if (line_close)
                    next_st = line_crop_end ? dcmi_pkg::WAIT_FRAME_END
                                            : dcmi_pkg::WAIT_LINE_START;
            end
            dcmi_pkg::WAIT_FRAME_END: begin
                if (frame_close)
                    next_st = dcmi_pkg::FRAME_END;
            end
            dcmi_pkg::FRAME_END: begin
                if (snapshot_mode || !capture_en)
                    next_st = dcmi_pkg::IDLE;
                else
                    next_st = dcmi_pkg::WAIT_FRAME_START;
            end
            default: next_st = dcmi_pkg::IDLE;
        endcase
    end

    // --------------------
    // state strobes
    // --------------------
    assign frame_begin = (curr_st == dcmi_pkg::WAIT_FRAME_START) &&
                         (next_st != dcmi_pkg::WAIT_FRAME_START);
    assign line_begin  = (curr_st != dcmi_pkg::LINE_RECV) && (next_st == dcmi_pkg::LINE_RECV);
    assign line_done   = (curr_st == dcmi_pkg::LINE_RECV) && (next_st != dcmi_pkg::LINE_RECV);
    assign in_line     = (curr_st == dcmi_pkg::LINE_RECV);
    assign frame_done  = (curr_st == dcmi_pkg::FRAME_END);

    // irq pulses one cycle after each event
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            line_irq_pulse        <= 1'b0;
            frame_start_irq_pulse <= 1'b0;
            frame_end_irq_pulse   <= 1'b0;
        end else if (!block_en) begin
            line_irq_pulse        <= 1'b0;
            frame_start_irq_pulse <= 1'b0;
            frame_end_irq_pulse   <= 1'b0;
        end else begin
            line_irq_pulse        <= line_begin;
            frame_start_irq_pulse <= frame_begin;
            frame_end_irq_pulse   <= frame_done;
        end
    end

endmodule

// File: src/dcmi_crop_window.sv
// dcmi crop window: line and pixel counters that gate capture and end the window
`timescale 1ns/1ps

module dcmi_crop_window (
    input  logic                       pclk,
    input  logic                       rstn,
    input  logic                       block_en,
    input  logic                       crop_en,
    input  logic [dcmi_pkg::CNT_W-1:0] line_crop_start,
    input  logic [dcmi_pkg::CNT_W-1:0] pixel_crop_start,
    input  logic [dcmi_pkg::CNT_W-1:0] line_crop_size,
    input  logic [dcmi_pkg::CNT_W-1:0] pixel_crop_size,
    input  logic                       frame_begin,
    input  logic                       line_begin,
    input  logic                       line_done,
    input  logic                       in_line,
    output logic                       in_window,
    output logic                       pixel_crop_end,
    output logic                       line_crop_end
);

    logic [dcmi_pkg::CNT_W-1:0] line_cnt;
    logic                       line_active;
    logic [dcmi_pkg::CNT_W-1:0] pixel_cnt;
    logic                       pixel_active;
    logic                       last_line_hit;
    logic                       last_line_seen;

    assign last_line_hit = line_active && (line_cnt == line_crop_size - 1'b1);

    // --------------------
    // line counter
    // --------------------
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            line_cnt       <= '0;
            line_active    <= 1'b0;
            last_line_seen <= 1'b0;
        end else if (!block_en) begin
            line_cnt       <= '0;
            line_active    <= 1'b0;
            last_line_seen <= 1'b0;
        end else if (frame_begin) begin
            line_cnt       <= '0;
            line_active    <= !(crop_en && line_crop_start != '0);
            last_line_seen <= 1'b0;
        end else if (line_done) begin
            last_line_seen <= last_line_hit;    // held while waiting for hsync end
            if (!line_active && line_cnt == line_crop_start - 1'b1) begin
                line_cnt    <= '0;              // window opens, restart from zero
                line_active <= 1'b1;
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // pixel counter
    // --------------------
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            pixel_cnt    <= '0;
            pixel_active <= 1'b0;
        end else if (!block_en) begin
            pixel_cnt    <= '0;
            pixel_active <= 1'b0;
        end else if (line_begin) begin
            pixel_cnt    <= '0;
            pixel_active <= !(crop_en && pixel_crop_start != '0);
        end else if (in_line) begin
            if (!pixel_active && pixel_cnt == pixel_crop_start - 1'b1) begin
                pixel_cnt    <= '0;
                pixel_active <= 1'b1;
            end else begin
                pixel_cnt <= pixel_cnt + 1'b1;
            end
        end
    end

    assign in_window = in_line & (~crop_en | (line_active & pixel_active));

    assign pixel_crop_end = crop_en & in_line & pixel_active &
                            (pixel_cnt == pixel_crop_size - 1'b1);
    // line count has already moved on once the line left LINE_RECV early
    assign line_crop_end  = crop_en & (in_line ? last_line_hit : last_line_seen);

endmodule

// File: src/dcmi_pixel_pack.sv
// dcmi pixel packer: places samples into 32-bit words and registers the output
`timescale 1ns/1ps

module dcmi_pixel_pack (
    input  logic                        pclk,
    input  logic                        rstn,
    input  logic                        block_en,
    input  dcmi_pkg::bus_width_t        data_bus_width,
    input  logic [dcmi_pkg::DATA_W-1:0] sample,
    input  logic                        href,
    input  logic                        in_line,
    input  logic                        in_window,
    input  logic                        frame_begin,
    input  logic                        frame_done,
    output logic [dcmi_pkg::WORD_W-1:0] dout,
    output logic                        dout_vld
);

    logic                        take;
    logic [1:0]                  lane_cnt;
    logic [1:0]                  lane_max;
    logic [dcmi_pkg::WORD_W-1:0] word_base;
    logic [dcmi_pkg::WORD_W-1:0] word_next;
    logic [dcmi_pkg::WORD_W-1:0] pixel_word;
    logic                        pixel_word_vld;

    assign take     = in_line & in_window & href;
    assign lane_max = (data_bus_width == dcmi_pkg::W8) ? dcmi_pkg::LANE_MAX_8B
                                                       : dcmi_pkg::LANE_MAX_16B;

    // a new word starts from zero, so unfilled lanes stay clear
    always_comb begin
        word_base = (lane_cnt == 2'd0) ? '0 : pixel_word;
        word_next = word_base;
        if (data_bus_width == dcmi_pkg::W8)
            word_next[{lane_cnt, 3'b000} +: dcmi_pkg::BYTE_W] = sample[dcmi_pkg::BYTE_W-1:0];
        else
            word_next[{lane_cnt[0], 4'b0000} +: dcmi_pkg::HALF_W] =
                {{(dcmi_pkg::HALF_W-dcmi_pkg::DATA_W){1'b0}}, sample};
    end

    // --------------------
    // stage 1, assemble
    // --------------------
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            lane_cnt       <= 2'd0;
            pixel_word     <= '0;
            pixel_word_vld <= 1'b0;
        end else if (!block_en || frame_begin) begin
            lane_cnt       <= 2'd0;
            pixel_word     <= '0;
            pixel_word_vld <= 1'b0;
        end else if (take) begin
            pixel_word     <= word_next;
            pixel_word_vld <= (lane_cnt == lane_max);   // word full
            lane_cnt       <= (lane_cnt == lane_max) ? 2'd0 : lane_cnt + 2'd1;
        end else if (frame_done) begin
            pixel_word_vld <= (lane_cnt != 2'd0);       // flush partial word
            lane_cnt       <= 2'd0;
        end else begin
            pixel_word_vld <= 1'b0;
        end
    end

    // --------------------
    // stage 2, output
    // --------------------
    always_ff @(posedge pclk or negedge rstn) begin
        if (!rstn) begin
            dout     <= '0;
            dout_vld <= 1'b0;
        end else if (!block_en) begin
            dout     <= '0;
            dout_vld <= 1'b0;
        end else begin
            dout_vld <= pixel_word_vld;
            if (pixel_word_vld)
                dout <= pixel_word;     // held until the next word
        end
    end

endmodule

// File: src/dcmi_capture_top.sv
// dcmi capture top level: input sync, frame fsm, crop window and word packer
`timescale 1ns/1ps

module dcmi_capture_top (
    input  logic                        pclk,
    input  logic                        rstn,
    input  logic                        dcmi_vsync,
    input  logic                        dcmi_hsync,
    input  logic [dcmi_pkg::DATA_W-1:0] dcmi_data,
    input  logic                        block_en,
    input  logic                        capture_en,
    input  logic                        snapshot_mode,
    input  logic                        crop_en,
    input  logic                        hsync_polarity,
    input  logic                        vsync_polarity,
    input  dcmi_pkg::bus_width_t        data_bus_width,
    input  logic [dcmi_pkg::CNT_W-1:0]  line_crop_start,
    input  logic [dcmi_pkg::CNT_W-1:0]  pixel_crop_start,
    input  logic [dcmi_pkg::CNT_W-1:0]  line_crop_size,
    input  logic [dcmi_pkg::CNT_W-1:0]  pixel_crop_size,
    output logic                        line_irq_pulse,
    output logic                        frame_start_irq_pulse,
    output logic                        frame_end_irq_pulse,
    output logic [dcmi_pkg::WORD_W-1:0] dout,
    output logic                        dout_vld
);

    logic [dcmi_pkg::DATA_W-1:0] sample;
    logic                        href;
    logic                        frame_open, frame_close;
    logic                        line_open, line_close;
    logic                        frame_begin, frame_done;
    logic                        line_begin, line_done, in_line;
    logic                        in_window, pixel_crop_end, line_crop_end;

    dcmi_sync_in sync_in_i (
        .pclk(pclk), .rstn(rstn), .block_en(block_en),
        .hsync_polarity(hsync_polarity), .vsync_polarity(vsync_polarity),
        .data_bus_width(data_bus_width),
        .dcmi_vsync(dcmi_vsync), .dcmi_hsync(dcmi_hsync), .dcmi_data(dcmi_data),
        .sample(sample), .href(href),
        .frame_open(frame_open), .frame_close(frame_close),
        .line_open(line_open), .line_close(line_close)
    );

    dcmi_frame_fsm frame_fsm_i (
        .pclk(pclk), .rstn(rstn), .block_en(block_en),
        .capture_en(capture_en), .snapshot_mode(snapshot_mode),
        .frame_open(frame_open), .frame_close(frame_close),
        .line_open(line_open), .line_close(line_close),
        .pixel_crop_end(pixel_crop_end), .line_crop_end(line_crop_end),
        .frame_begin(frame_begin), .line_begin(line_begin), .line_done(line_done),
        .in_line(in_line), .frame_done(frame_done),
        .line_irq_pulse(line_irq_pulse), .frame_start_irq_pulse(frame_start_irq_pulse),
        .frame_end_irq_pulse(frame_end_irq_pulse)
    );

    dcmi_crop_window crop_window_i (
        .pclk(pclk), .rstn(rstn), .block_en(block_en), .crop_en(crop_en),
        .line_crop_start(line_crop_start), .pixel_crop_start(pixel_crop_start),
        .line_crop_size(line_crop_size), .pixel_crop_size(pixel_crop_size),
        .frame_begin(frame_begin), .line_begin(line_begin),
        .line_done(line_done), .in_line(in_line),
        .in_window(in_window), .pixel_crop_end(pixel_crop_end),
        .line_crop_end(line_crop_end)
    );

    dcmi_pixel_pack pixel_pack_i (
        .pclk(pclk), .rstn(rstn), .block_en(block_en),
        .data_bus_width(data_bus_width), .sample(sample), .href(href),
        .in_line(in_line), .in_window(in_window),
        .frame_begin(frame_begin), .frame_done(frame_done),
        .dout(dout), .dout_vld(dout_vld)
    );

endmodule

// File: bench/dcmi_checker.sv
// dcmi result checker: compares output words and counts irq pulses per test row
`timescale 1ns/1ps

module dcmi_checker #(
    parameter int MAX_WORDS = 64
) (
    input  logic                        pclk,
    input  logic                        rstn,
    input  logic [dcmi_pkg::WORD_W-1:0] dout,
    input  logic                        dout_vld,
    input  logic                        line_irq_pulse,
    input  logic                        frame_start_irq_pulse,
    input  logic                        frame_end_irq_pulse,
    input  logic                        row_start,
    input  logic                        row_end,
    input  int                          row_idx,
    input  logic [dcmi_pkg::WORD_W-1:0] exp_words [MAX_WORDS],
    input  int                          exp_word_cnt,
    input  int                          exp_line_irqs,
    input  int                          exp_frames,
    output int                          words_seen,
    output int                          frame_ends_seen,
    output int                          error_cnt,
    output int                          rows_failed
);

    int line_irqs;
    int frame_starts;
    int row_errs;

    initial begin
        error_cnt   = 0;
        rows_failed = 0;
    end

    task automatic compare_count(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("ERR @%0t: row %0d %0s count %0d, expected %0d",
                     $time, row_idx, what, got, expected);
            row_errs++;
            error_cnt++;
        end
    endtask

    // --------------------
    // per row bookkeeping
    // --------------------
    always @(posedge pclk) begin
        if (!rstn || row_start) begin
            words_seen      = 0;
            frame_ends_seen = 0;
            line_irqs       = 0;
            frame_starts    = 0;
            row_errs        = 0;
            if (!rstn && (dout_vld || line_irq_pulse || frame_start_irq_pulse ||
                          frame_end_irq_pulse)) begin
                $display("ERR @%0t: outputs active during reset", $time);
                error_cnt++;
            end
        end else begin
            if (dout_vld) begin
                if (words_seen >= exp_word_cnt) begin
                    $display("ERR @%0t: row %0d extra word %h", $time, row_idx, dout);
                    row_errs++;
                    error_cnt++;
                end else if (dout !== exp_words[words_seen]) begin
                    $display("ERR @%0t: row %0d word %0d is %h, expected %h",
                             $time, row_idx, words_seen, dout, exp_words[words_seen]);
                    row_errs++;
                    error_cnt++;
                end
                words_seen++;
            end
            if (line_irq_pulse)
                line_irqs++;
            if (frame_start_irq_pulse)
                frame_starts++;
            if (frame_end_irq_pulse)
                frame_ends_seen++;
            if (row_end) begin
                compare_count("word", words_seen, exp_word_cnt);
                compare_count("line_irq", line_irqs, exp_line_irqs);
                compare_count("frame_start_irq", frame_starts, exp_frames);
                compare_count("frame_end_irq", frame_ends_seen, exp_frames);
                if (row_errs == 0) begin
                    $display("row %0d PASS, %0d words", row_idx, words_seen);
                end else begin
                    $display("row %0d failed with %0d errors", row_idx, row_errs);
                    rows_failed++;
                end
            end
        end
    end

endmodule

// File: bench/dcmi_tb.sv
// dcmi capture testbench: table driven frame generator around the capture top level
`timescale 1ns/1ps

module dcmi_tb;

    localparam int MAX_WORDS = 64;
    localparam int N_ROWS    = 10;
    localparam int TIMEOUT   = 2000;   // cycles per wait

    typedef struct packed {
        int width;      // bus width code
        int hpol;
        int vpol;
        int snap;
        int crop;
        int lstart;
        int pstart;
        int lsize;
        int psize;
        int frames;
        int lines;
        int pixels;
        int gap;        // idle cycles around the strobes
    } row_t;

    logic                        pclk, rstn;
    logic                        dcmi_vsync, dcmi_hsync;
    logic [dcmi_pkg::DATA_W-1:0] dcmi_data;
    logic                        block_en, capture_en, snapshot_mode, crop_en;
    logic                        hsync_polarity, vsync_polarity;
    dcmi_pkg::bus_width_t        data_bus_width;
    logic [dcmi_pkg::CNT_W-1:0]  line_crop_start, pixel_crop_start;
    logic [dcmi_pkg::CNT_W-1:0]  line_crop_size, pixel_crop_size;
    logic                        line_irq_pulse, frame_start_irq_pulse, frame_end_irq_pulse;
    logic [dcmi_pkg::WORD_W-1:0] dout;
    logic                        dout_vld;

    logic                        row_start, row_end;
    int                          row_idx;
    logic [dcmi_pkg::WORD_W-1:0] exp_words [MAX_WORDS];
    int                          exp_word_cnt, exp_line_irqs, exp_frames;
    int                          words_seen, frame_ends_seen, error_cnt, rows_failed;

    row_t                        rows [N_ROWS];
    logic [dcmi_pkg::DATA_W-1:0] pix_q [$];
    int                          seed;
    int                          rows_run;
    bit                          timed_out;

    dcmi_capture_top dut_i (.*);

    dcmi_checker #(.MAX_WORDS(MAX_WORDS)) checker_i (.*);

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(posedge pclk);
    endtask

    // pixel values for every frame, and the words the packing rules give for them
    task automatic build_expect(input row_t r);
        logic [31:0]                 rnd;
        logic [dcmi_pkg::DATA_W-1:0] val;
        logic [dcmi_pkg::WORD_W-1:0] word;
        int                          lane;
        int                          spw;
        int                          mask;
        int                          win_lines;
        bit                          in_win;
        spw           = (r.width == 0) ? 4 : 2;
        mask          = (1 << (8 + 2 * r.width)) - 1;  // 8, 10, 12 or 14 bits
        exp_frames    = r.snap ? 1 : r.frames;
        win_lines     = (r.lstart + r.lsize < r.lines) ? r.lstart + r.lsize : r.lines;
        exp_line_irqs = exp_frames * (r.crop ? win_lines : r.lines);
        exp_word_cnt  = 0;
        pix_q.delete();
        for (int f = 0; f < r.frames; f++) begin
            word = '0;
            lane = 0;
            for (int l = 0; l < r.lines; l++) begin
                for (int p = 0; p < r.pixels; p++) begin
                    rnd = $random(seed);
                    val = rnd[dcmi_pkg::DATA_W-1:0];   // upper pins driven too
                    pix_q.push_back(val);
                    in_win = (r.crop == 0) ||
                             (l >= r.lstart && l < r.lstart + r.lsize &&
                              p >= r.pstart && p < r.pstart + r.psize);
                    if (f < exp_frames && in_win) begin
                        if (spw == 4)
                            word[lane * 8 +: 8] = val[7:0];
                        else
                            word[lane * 16 +: 16] = 16'(int'(val) & mask);
                        lane++;
                        if (lane == spw) begin
                            exp_words[exp_word_cnt] = word;
                            exp_word_cnt++;
                            word = '0;
                            lane = 0;
                        end
                    end
                end
            end
            if (lane != 0) begin    // partial word at frame end
                exp_words[exp_word_cnt] = word;
                exp_word_cnt++;
            end
        end
    endtask

    // --------------------
    // frame generator
    // --------------------
    task automatic send_frames(input row_t r);
        for (int f = 0; f < r.frames; f++) begin
            @(posedge pclk);
            dcmi_vsync <= r.vpol[0];    // frame active
            idle_cycles(r.gap);
            for (int l = 0; l < r.lines; l++) begin
                for (int p = 0; p < r.pixels; p++) begin
                    @(posedge pclk);
                    dcmi_hsync <= r.hpol[0];
                    dcmi_data  <= pix_q.pop_front();
                end
                @(posedge pclk);
                dcmi_hsync <= ~r.hpol[0];
                idle_cycles(r.gap - 1);
            end
            @(posedge pclk);
            dcmi_vsync <= ~r.vpol[0];
            idle_cycles(2);
            // fsm has just left frame end, continuous mode would be armed again
            if (r.snap != 0)
                capture_en <= 1'b0;
            idle_cycles(r.gap - 2);
        end
    endtask

    task automatic wait_done(output bit expired);
        int waited;
        waited = 0;
        do begin
            @(negedge pclk);
            waited++;
        end while ((words_seen < exp_word_cnt || frame_ends_seen < exp_frames) &&
                   waited < TIMEOUT);
        expired = (words_seen < exp_word_cnt || frame_ends_seen < exp_frames);
        if (expired)
            $display("timeout in row %0d: %0d of %0d words, %0d of %0d frame ends",
                     row_idx, words_seen, exp_word_cnt, frame_ends_seen, exp_frames);
    endtask

    initial begin
        seed     = 32'h60dc;
        rows_run = 0;
        timed_out = 1'b0;
        //          wd hp vp sn cr ls ps lz pz fr ln px gap
        rows[0] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 2, 3, 8, 3};
        rows[1] = '{1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 6, 2};
        rows[2] = '{2, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 4, 2};
        rows[3] = '{3, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 6, 3};
        rows[4] = '{0, 0, 0, 0, 1, 1, 2, 2, 4, 2, 5, 10, 3};
        rows[5] = '{0, 1, 1, 0, 0, 0, 0, 0, 0, 2, 3, 8, 3};
        rows[6] = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 2, 2, 8, 3};
        rows[7] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 5, 2};
        rows[8] = '{2, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 3, 2};
        rows[9] = '{1, 0, 0, 0, 1, 0, 1, 2, 3, 1, 4, 6, 2};

        rstn <= 1'b0;
        block_en <= 1'b0;
        capture_en <= 1'b0;
        snapshot_mode <= 1'b0;
        crop_en <= 1'b0;
        hsync_polarity <= 1'b0;
        vsync_polarity <= 1'b0;
        data_bus_width <= dcmi_pkg::W8;
        line_crop_start <= '0;
        pixel_crop_start <= '0;
        line_crop_size <= '0;
        pixel_crop_size <= '0;
        dcmi_vsync <= 1'b1;
        dcmi_hsync <= 1'b1;
        dcmi_data <= '0;
        row_start <= 1'b0;
        row_end <= 1'b0;
        row_idx <= 0;
        idle_cycles(5);
        rstn <= 1'b1;

        for (int r = 0; r < N_ROWS; r++) begin
            idle_cycles(1);
            build_expect(rows[r]);
            // settings change only while the block is held off
            block_en <= 1'b0;
            capture_en <= 1'b0;
            snapshot_mode <= rows[r].snap[0];
            crop_en <= rows[r].crop[0];
            hsync_polarity <= rows[r].hpol[0];
            vsync_polarity <= rows[r].vpol[0];
            data_bus_width <= dcmi_pkg::bus_width_t'(rows[r].width[1:0]);
            line_crop_start <= rows[r].lstart[dcmi_pkg::CNT_W-1:0];
            pixel_crop_start <= rows[r].pstart[dcmi_pkg::CNT_W-1:0];
            line_crop_size <= rows[r].lsize[dcmi_pkg::CNT_W-1:0];
            pixel_crop_size <= rows[r].psize[dcmi_pkg::CNT_W-1:0];
            dcmi_vsync <= ~rows[r].vpol[0];
            dcmi_hsync <= ~rows[r].hpol[0];
            row_idx <= r;
            row_start <= 1'b1;
            @(posedge pclk);
            row_start <= 1'b0;
            block_en <= 1'b1;
            capture_en <= 1'b1;
            idle_cycles(rows[r].gap);
            send_frames(rows[r]);
            wait_done(timed_out);
            rows_run++;
            if (timed_out)
                break;
            @(posedge pclk);
            row_end <= 1'b1;
            @(posedge pclk);
            row_end <= 1'b0;
        end

        @(negedge pclk);
        $display("rows run %0d, rows failed %0d, errors %0d", rows_run, rows_failed, error_cnt);
        if (timed_out || error_cnt != 0 || rows_failed != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

// File: all.f
src/dcmi_pkg.sv
src/dcmi_sync_in.sv
src/dcmi_frame_fsm.sv
src/dcmi_crop_window.sv
src/dcmi_pixel_pack.sv
src/dcmi_capture_top.sv
bench/dcmi_checker.sv
bench/dcmi_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = dcmi_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
